//--- design/ao_peripheral.sv
// ##################################################################
// always-on peripheral block, exit and boot registers, GPIO bank
// with rising-edge interrupts onto the fast interrupt range
// ##################################################################
`timescale 1ns/1ns
`default_nettype none

module ao_peripheral #(
  parameter int unsigned NUM_GPIO = 8
) (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  obi_bus_if.subordinate           bus,
  input  wire logic                boot_select_i,
  output logic                     exit_valid_o,
  output mini_mcu_pkg::data_t      exit_value_o,
  input  wire logic [NUM_GPIO-1:0] gpio_i,
  output logic [NUM_GPIO-1:0]      gpio_o,
  output logic [NUM_GPIO-1:0]      gpio_oe_o,
  output mini_mcu_pkg::data_t      intr_o
);

  import mini_mcu_pkg::*;

  if (NUM_GPIO < 1 || NUM_GPIO > MAX_GPIO) begin : g_bad_gpio_count
    $error("NUM_GPIO out of range");
  end

  bus_addr_u addr;
  logic wr_en;
  logic exit_valid_q;
  data_t exit_value_q;
  logic [NUM_GPIO-1:0] gpio_out_q;
  logic [NUM_GPIO-1:0] gpio_oe_q;
  logic [NUM_GPIO-1:0] intr_en_q;
  logic [NUM_GPIO-1:0] intr_status_q;
  logic [NUM_GPIO-1:0] gpio_meta_q;
  logic [NUM_GPIO-1:0] gpio_sync_q;
  logic [NUM_GPIO-1:0] gpio_prev_q;
  logic [NUM_GPIO-1:0] gpio_rise;
  logic [NUM_GPIO-1:0] status_clr;
  data_t rdata_d;
  data_t rdata_q;
  logic rvalid_q;

  assign addr = bus.addr;
  assign bus.gnt = bus.req;
  assign wr_en = bus.req & bus.we;

  assign gpio_rise = gpio_sync_q & ~gpio_prev_q;
  // write one to clear
  assign status_clr = (wr_en && addr.periph.reg_off == REG_GPIO_INTR_STATUS) ?
                      bus.wdata[NUM_GPIO-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      gpio_out_q <= '0;
      gpio_oe_q <= '0;
      intr_en_q <= '0;
      intr_status_q <= '0;
      gpio_meta_q <= '0;
      gpio_sync_q <= '0;
      gpio_prev_q <= '0;
      rvalid_q <= 1'b0;
    end else begin
      gpio_meta_q <= gpio_i;
      gpio_sync_q <= gpio_meta_q;
      gpio_prev_q <= gpio_sync_q;
      // a new edge wins over a clear in the same cycle
      intr_status_q <= (intr_status_q & ~status_clr) | gpio_rise;
      rvalid_q <= bus.req & bus.gnt;
      if (wr_en) begin
        case (addr.periph.reg_off)
          REG_EXIT_VALID: exit_valid_q <= bus.wdata[0];
          REG_EXIT_VALUE: exit_value_q <= bus.wdata;
          REG_GPIO_OUT: gpio_out_q <= bus.wdata[NUM_GPIO-1:0];
          REG_GPIO_OE: gpio_oe_q <= bus.wdata[NUM_GPIO-1:0];
          REG_GPIO_INTR_EN: intr_en_q <= bus.wdata[NUM_GPIO-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_d = '0;
    case (addr.periph.reg_off)
      REG_EXIT_VALID: rdata_d[0] = exit_valid_q;
      REG_EXIT_VALUE: rdata_d = exit_value_q;
      REG_BOOT_SELECT: rdata_d[0] = boot_select_i;
      REG_GPIO_OUT: rdata_d[NUM_GPIO-1:0] = gpio_out_q;
      REG_GPIO_OE: rdata_d[NUM_GPIO-1:0] = gpio_oe_q;
      REG_GPIO_IN: rdata_d[NUM_GPIO-1:0] = gpio_sync_q;
      REG_GPIO_INTR_EN: rdata_d[NUM_GPIO-1:0] = intr_en_q;
      REG_GPIO_INTR_STATUS: rdata_d[NUM_GPIO-1:0] = intr_status_q;
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (bus.req && !bus.we) begin
      rdata_q <= rdata_d;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata = rdata_q;

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;
  assign gpio_o = gpio_out_q;
  assign gpio_oe_o = gpio_oe_q;

  // pin i lands on fast interrupt i
  always_comb begin
    intr_o = '0;
    intr_o[FAST_INTR_BASE +: NUM_GPIO] = intr_status_q & intr_en_q;
  end

endmodule

`default_nettype wire

//--- design/memory_banks.sv
// ##################################################################
// banked on-chip word RAM with byte enables
// ##################################################################
`timescale 1ns/1ns
`default_nettype none

module memory_banks (
  input  wire logic        clk_i,
  input  wire logic        arst_n_i,
  obi_bus_if.subordinate   bus
);

  import mini_mcu_pkg::*;

  data_t mem_q [NUM_BANKS][BANK_WORDS];
  bus_addr_u addr;
  be_t be;
  data_t rdata_q;
  logic rvalid_q;

  assign addr = bus.addr;
  assign be = bus.be;

  // always ready
  assign bus.gnt = bus.req;

  always_ff @(posedge clk_i) begin
    if (bus.req && bus.we) begin
      for (int b = 0; b < DATA_W / 8; b++) begin
        if (be[b]) begin
          mem_q[addr.ram.bank][addr.ram.word][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
    if (bus.req && !bus.we) begin
      rdata_q <= mem_q[addr.ram.bank][addr.ram.word];
    end
  end

  // one response per accepted request
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req & bus.gnt;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/mini_mcu.sv
// ##################################################################
// mini MCU top level, external bus port onto RAM and always-on block
// ##################################################################
`timescale 1ns/1ns
`default_nettype none

module mini_mcu #(
  parameter int unsigned NUM_GPIO = 8
) (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,

  input  wire logic                  bus_req_i,
  input  wire logic                  bus_we_i,
  input  wire mini_mcu_pkg::addr_t   bus_addr_i,
  input  wire mini_mcu_pkg::be_t     bus_be_i,
  input  wire mini_mcu_pkg::data_t   bus_wdata_i,
  output logic                       bus_gnt_o,
  output logic                       bus_rvalid_o,
  output mini_mcu_pkg::data_t        bus_rdata_o,

  input  wire logic                  boot_select_i,
  output logic                       exit_valid_o,
  output mini_mcu_pkg::data_t        exit_value_o,

  input  wire logic [NUM_GPIO-1:0]   gpio_i,
  output logic [NUM_GPIO-1:0]        gpio_o,
  output logic [NUM_GPIO-1:0]        gpio_oe_o,
  output mini_mcu_pkg::data_t        intr_o
);

  obi_bus_if host_bus ();
  obi_bus_if ram_bus ();
  obi_bus_if ao_bus ();

  // external master onto the host side of the bus
  assign host_bus.req = bus_req_i;
  assign host_bus.we = bus_we_i;
  assign host_bus.addr = bus_addr_i;
  assign host_bus.be = bus_be_i;
  assign host_bus.wdata = bus_wdata_i;
  assign bus_gnt_o = host_bus.gnt;
  assign bus_rvalid_o = host_bus.rvalid;
  assign bus_rdata_o = host_bus.rdata;

  system_bus u_system_bus (
    .clk_i,
    .arst_n_i,
    .host_bus(host_bus.subordinate),
    .ram_bus(ram_bus.manager),
    .ao_bus(ao_bus.manager)
  );

  memory_banks u_memory_banks (
    .clk_i,
    .arst_n_i,
    .bus(ram_bus.subordinate)
  );

  ao_peripheral #(
    .NUM_GPIO(NUM_GPIO)
  ) u_ao_peripheral (
    .clk_i,
    .arst_n_i,
    .bus(ao_bus.subordinate),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o,
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .intr_o
  );

endmodule

`default_nettype wire

//--- design/mini_mcu_pkg.sv
// ##################################################################
// mini MCU shared definitions
// bus types, address map, register offsets and the address union
// ##################################################################
`default_nettype none

package mini_mcu_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [DATA_W/8-1:0] be_t;

  // upper half of the address picks the slave
  localparam int unsigned REGION_W = 16;
  localparam logic [REGION_W-1:0] RAM_REGION = 16'h0000;
  localparam logic [REGION_W-1:0] AO_REGION = 16'h2000;

  localparam int unsigned NUM_BANKS = 2;
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_W = $clog2(NUM_BANKS);
  localparam int unsigned WORD_W = $clog2(BANK_WORDS);
  localparam int unsigned REG_OFF_W = 6;

  typedef struct packed {
    logic [REGION_W-1:0] region;
    logic [ADDR_W-REGION_W-BANK_W-WORD_W-3:0] spare;
    logic [BANK_W-1:0] bank;
    logic [WORD_W-1:0] word;
    logic [1:0] byte_idx;
  } ram_addr_t;

  typedef struct packed {
    logic [REGION_W-1:0] region;
    logic [ADDR_W-REGION_W-REG_OFF_W-3:0] spare;
    logic [REG_OFF_W-1:0] reg_off;
    logic [1:0] byte_idx;
  } periph_addr_t;

  // same address word, seen by RAM or by the always-on block
  typedef union packed {
    ram_addr_t ram;
    periph_addr_t periph;
  } bus_addr_u;

  // always-on register word offsets
  localparam logic [REG_OFF_W-1:0] REG_EXIT_VALID = 6'd0;
  localparam logic [REG_OFF_W-1:0] REG_EXIT_VALUE = 6'd1;
  localparam logic [REG_OFF_W-1:0] REG_BOOT_SELECT = 6'd2;
  localparam logic [REG_OFF_W-1:0] REG_GPIO_OUT = 6'd4;
  localparam logic [REG_OFF_W-1:0] REG_GPIO_OE = 6'd5;
  localparam logic [REG_OFF_W-1:0] REG_GPIO_IN = 6'd6;
  localparam logic [REG_OFF_W-1:0] REG_GPIO_INTR_EN = 6'd7;
  localparam logic [REG_OFF_W-1:0] REG_GPIO_INTR_STATUS = 6'd8;

  localparam int unsigned FAST_INTR_BASE = 16;
  localparam data_t UNMAPPED_RDATA = 32'hbadcab1e;
  // fast range ends at bit 30, bit 31 stays 0
  localparam int unsigned MAX_GPIO = 15;

endpackage

`default_nettype wire

//--- design/obi_bus_if.sv
// ##################################################################
// OBI request and response bundle, one manager and one subordinate
// ##################################################################
`timescale 1ns/1ns
`default_nettype none

interface obi_bus_if;

  // request side
  logic req;
  logic gnt;
  logic [31:0] addr;
  logic we;
  logic [3:0] be;
  logic [31:0] wdata;

  // response side, one cycle after the grant
  logic rvalid;
  logic [31:0] rdata;

  modport manager(output req, addr, we, be, wdata, input gnt, rvalid, rdata);

  modport subordinate(input req, addr, we, be, wdata, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

//--- design/system_bus.sv
// ##################################################################
// system bus, routes host requests to RAM or the always-on block
// and answers unmapped space itself
// ##################################################################
`timescale 1ns/1ns
`default_nettype none

module system_bus (
  input  wire logic        clk_i,
  input  wire logic        arst_n_i,
  obi_bus_if.subordinate   host_bus,
  obi_bus_if.manager       ram_bus,
  obi_bus_if.manager       ao_bus
);

  import mini_mcu_pkg::*;

  bus_addr_u host_addr;
  logic sel_ram;
  logic sel_ao;
  logic accepted;

  // target of the request in flight
  logic rsp_ram_q;
  logic rsp_ao_q;
  logic rsp_unmapped_q;

  assign host_addr = host_bus.addr;
  assign sel_ram = (host_addr.ram.region == RAM_REGION);
  assign sel_ao = (host_addr.periph.region == AO_REGION);

  // req only to the matching slave, payload to both
  assign ram_bus.req = host_bus.req & sel_ram;
  assign ram_bus.addr = host_bus.addr;
  assign ram_bus.we = host_bus.we;
  assign ram_bus.be = host_bus.be;
  assign ram_bus.wdata = host_bus.wdata;

  assign ao_bus.req = host_bus.req & sel_ao;
  assign ao_bus.addr = host_bus.addr;
  assign ao_bus.we = host_bus.we;
  assign ao_bus.be = host_bus.be;
  assign ao_bus.wdata = host_bus.wdata;

  // unmapped space grants at once
  assign host_bus.gnt = sel_ram ? ram_bus.gnt : (sel_ao ? ao_bus.gnt : host_bus.req);
  assign accepted = host_bus.req & host_bus.gnt;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_ram_q <= 1'b0;
      rsp_ao_q <= 1'b0;
      rsp_unmapped_q <= 1'b0;
    end else begin
      rsp_ram_q <= accepted & sel_ram;
      rsp_ao_q <= accepted & sel_ao;
      rsp_unmapped_q <= accepted & ~sel_ram & ~sel_ao;
    end
  end

  assign host_bus.rvalid = (rsp_ram_q & ram_bus.rvalid) |
                           (rsp_ao_q & ao_bus.rvalid) |
                           rsp_unmapped_q;

  always_comb begin
    if (rsp_ram_q) begin
      host_bus.rdata = ram_bus.rdata;
    end else if (rsp_ao_q) begin
      host_bus.rdata = ao_bus.rdata;
    end else begin
      host_bus.rdata = UNMAPPED_RDATA;
    end
  end

endmodule

`default_nettype wire

//--- flist.f
design/mini_mcu_pkg.sv
design/obi_bus_if.sv
design/system_bus.sv
design/memory_banks.sv
design/ao_peripheral.sv
design/mini_mcu.sv
tb/mini_mcu_properties.sv
tb/tb_mini_mcu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mini MCU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f flist.f --top-module tb_mini_mcu -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vtb_mini_mcu" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

//--- tb/mini_mcu_properties.sv
// ##################################################################
// bus handshake and interrupt vector checks on the mini MCU ports
// ##################################################################
`timescale 1ns/1ns
`default_nettype none

module mini_mcu_properties (
  input wire logic                clk_i,
  input wire logic                arst_n_i,
  input wire logic                bus_req_i,
  input wire logic                bus_gnt_o,
  input wire logic                bus_rvalid_o,
  input wire mini_mcu_pkg::data_t intr_o
);

  import mini_mcu_pkg::*;

  int violations = 0;

  // a response needs an accepted request one cycle earlier
  rvalid_after_accept: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    bus_rvalid_o |-> $past(bus_req_i && bus_gnt_o)
  ) else begin
    violations++;
    $error("bus response without an accepted request");
  end

  gnt_equals_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    bus_gnt_o == bus_req_i
  ) else begin
    violations++;
    $error("bus grant differs from request");
  end

  intr_outside_fast_zero: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (intr_o[FAST_INTR_BASE-1:0] == '0) && (intr_o[DATA_W-1] == 1'b0)
  ) else begin
    violations++;
    $error("interrupt bit set outside the fast range");
  end

endmodule

bind mini_mcu mini_mcu_properties u_mini_mcu_properties (
  .clk_i(clk_i),
  .arst_n_i(arst_n_i),
  .bus_req_i(bus_req_i),
  .bus_gnt_o(bus_gnt_o),
  .bus_rvalid_o(bus_rvalid_o),
  .intr_o(intr_o)
);

`default_nettype wire

//--- tb/tb_mini_mcu.sv
// ##################################################################
// mini MCU testbench, table-driven bus traffic and GPIO interrupts
// ##################################################################
`timescale 1ns/1ns
`default_nettype none

module tb_mini_mcu;

  import mini_mcu_pkg::*;

  localparam int NUM_GPIO = 8;
  localparam int TIMEOUT_CYCLES = 40;
  localparam int IRQ_PIN = 3;

  typedef struct packed {
    logic we;
    addr_t addr;
    be_t be;
    data_t wdata;
    data_t exp;
    logic burst;
  } entry_t;

  logic clk_i = 1'b0;
  logic arst_n_i;
  logic bus_req_i;
  logic bus_we_i;
  addr_t bus_addr_i;
  be_t bus_be_i;
  data_t bus_wdata_i;
  logic bus_gnt_o;
  logic bus_rvalid_o;
  data_t bus_rdata_o;
  logic boot_select_i;
  logic exit_valid_o;
  data_t exit_value_o;
  logic [NUM_GPIO-1:0] gpio_i;
  logic [NUM_GPIO-1:0] gpio_o;
  logic [NUM_GPIO-1:0] gpio_oe_o;
  data_t intr_o;

  entry_t table_q[$];
  entry_t sent_q[$];
  int rsp_cnt = 0;
  int rsp_err_cnt = 0;
  int err_cnt = 0;
  int timeout_cnt = 0;
  logic [31:0] lfsr_q = 32'hf31b;

  mini_mcu #(
    .NUM_GPIO(NUM_GPIO)
  ) u_mini_mcu (
    .clk_i(clk_i),
    .arst_n_i(arst_n_i),
    .bus_req_i(bus_req_i),
    .bus_we_i(bus_we_i),
    .bus_addr_i(bus_addr_i),
    .bus_be_i(bus_be_i),
    .bus_wdata_i(bus_wdata_i),
    .bus_gnt_o(bus_gnt_o),
    .bus_rvalid_o(bus_rvalid_o),
    .bus_rdata_o(bus_rdata_o),
    .boot_select_i(boot_select_i),
    .exit_valid_o(exit_valid_o),
    .exit_value_o(exit_value_o),
    .gpio_i(gpio_i),
    .gpio_o(gpio_o),
    .gpio_oe_o(gpio_oe_o),
    .intr_o(intr_o)
  );

  always #10 clk_i = ~clk_i;

  // Galois LFSR x^32+x^22+x^2+x+1, one step per bit taken
  function automatic data_t take_bits(input int n);
    data_t bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      bits = {bits[30:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  function automatic addr_t ram_addr(input logic bank, input logic [7:0] word);
    return {16'h0000, 5'b00000, bank, word, 2'b00};
  endfunction

  function automatic addr_t ao_addr(input logic [5:0] reg_off);
    return {16'h2000, 8'h00, reg_off, 2'b00};
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input be_t be);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string what, input data_t got, input data_t exp,
                             inout int errors);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic add_entry(input logic we, input addr_t addr, input data_t wdata,
                           input data_t exp, input logic burst, input be_t be = 4'hf);
    table_q.push_back('{we, addr, be, wdata, exp, burst});
  endtask

  task automatic wait_responses();
    int cycles;
    cycles = 0;
    while (rsp_cnt != sent_q.size() && cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    if (rsp_cnt != sent_q.size()) begin
      timeout_cnt++;
      $display("timeout at %0t, %0d bus responses never came", $time,
               sent_q.size() - rsp_cnt);
    end
  endtask

  // a burst entry is followed by the next request in the very next cycle
  task automatic apply_table();
    foreach (table_q[i]) begin
      @(posedge clk_i);
      bus_req_i <= 1'b1;
      bus_we_i <= table_q[i].we;
      bus_addr_i <= table_q[i].addr;
      bus_be_i <= table_q[i].be;
      bus_wdata_i <= table_q[i].wdata;
      sent_q.push_back(table_q[i]);
      if (!table_q[i].burst) begin
        @(posedge clk_i);
        bus_req_i <= 1'b0;
        wait_responses();
      end
    end
    table_q.delete();
  endtask

  task automatic wait_irq(input int bit_idx);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!intr_o[bit_idx] && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!intr_o[bit_idx]) begin
      timeout_cnt++;
      $display("timeout at %0t, interrupt bit %0d never rose", $time, bit_idx);
    end
  endtask

  // responses return in request order
  always @(negedge clk_i) begin
    if (bus_rvalid_o) begin
      if (rsp_cnt >= sent_q.size()) begin
        rsp_err_cnt++;
        $display("bus response at %0t with no request outstanding", $time);
      end else begin
        if (!sent_q[rsp_cnt].we) begin
          check_value($sformatf("read data at %h", sent_q[rsp_cnt].addr), bus_rdata_o,
                      sent_q[rsp_cnt].exp, rsp_err_cnt);
        end
        rsp_cnt++;
      end
    end
  end

  initial begin
    data_t ram_w[4];
    data_t byte_w;
    data_t merged_w;
    data_t exit_w;
    logic [NUM_GPIO-1:0] gpio_out_val;
    logic [NUM_GPIO-1:0] gpio_oe_val;
    int assert_cnt;
    arst_n_i = 1'b0;
    bus_req_i = 1'b0;
    bus_we_i = 1'b0;
    bus_addr_i = '0;
    bus_be_i = '0;
    bus_wdata_i = '0;
    boot_select_i = 1'b1;
    gpio_i = '0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_value("exit_valid_o after reset", 32'(exit_valid_o), 32'h0, err_cnt);
    check_value("intr_o after reset", intr_o, 32'h0, err_cnt);

    // full words into both banks, then read back
    for (int i = 0; i < 4; i++) begin
      ram_w[i] = take_bits(32);
    end
    add_entry(1'b1, ram_addr(1'b0, 8'h03), ram_w[0], '0, 1'b0);
    add_entry(1'b1, ram_addr(1'b1, 8'h03), ram_w[1], '0, 1'b0);
    add_entry(1'b1, ram_addr(1'b0, 8'hff), ram_w[2], '0, 1'b0);
    add_entry(1'b1, ram_addr(1'b1, 8'hff), ram_w[3], '0, 1'b0);
    add_entry(1'b0, ram_addr(1'b0, 8'h03), '0, ram_w[0], 1'b0);
    add_entry(1'b0, ram_addr(1'b1, 8'h03), '0, ram_w[1], 1'b0);
    add_entry(1'b0, ram_addr(1'b0, 8'hff), '0, ram_w[2], 1'b0);
    add_entry(1'b0, ram_addr(1'b1, 8'hff), '0, ram_w[3], 1'b0);
    // byte write and two reads back to back
    byte_w = take_bits(32);
    merged_w = merge_bytes(ram_w[0], byte_w, 4'b0101);
    add_entry(1'b1, ram_addr(1'b0, 8'h03), byte_w, '0, 1'b1, 4'b0101);
    add_entry(1'b0, ram_addr(1'b0, 8'h03), '0, merged_w, 1'b1);
    add_entry(1'b0, ram_addr(1'b1, 8'h03), '0, ram_w[1], 1'b0);
    // unmapped write must not alias onto the RAM word with the same low bits
    add_entry(1'b1, 32'h1000_000c, ~byte_w, '0, 1'b0);
    add_entry(1'b0, 32'h1000_000c, '0, 32'hbadcab1e, 1'b0);
    add_entry(1'b0, ram_addr(1'b0, 8'h03), '0, merged_w, 1'b0);
    apply_table();

    exit_w = take_bits(32);
    add_entry(1'b1, ao_addr(REG_EXIT_VALUE), exit_w, '0, 1'b0);
    add_entry(1'b1, ao_addr(REG_EXIT_VALID), 32'h1, '0, 1'b0);
    add_entry(1'b0, ao_addr(REG_EXIT_VALUE), '0, exit_w, 1'b0);
    add_entry(1'b0, ao_addr(REG_BOOT_SELECT), '0, {31'b0, boot_select_i}, 1'b0);
    apply_table();
    @(negedge clk_i);
    check_value("exit_value_o", exit_value_o, exit_w, err_cnt);
    check_value("exit_valid_o", 32'(exit_valid_o), 32'h1, err_cnt);

    gpio_out_val = NUM_GPIO'(take_bits(NUM_GPIO));
    gpio_oe_val = NUM_GPIO'(take_bits(NUM_GPIO));
    add_entry(1'b1, ao_addr(REG_GPIO_OUT), 32'(gpio_out_val), '0, 1'b0);
    add_entry(1'b1, ao_addr(REG_GPIO_OE), 32'(gpio_oe_val), '0, 1'b0);
    apply_table();
    @(negedge clk_i);
    check_value("gpio_o", 32'(gpio_o), 32'(gpio_out_val), err_cnt);
    check_value("gpio_oe_o", 32'(gpio_oe_o), 32'(gpio_oe_val), err_cnt);
    // pin 3 stays low here so its edge comes later
    @(posedge clk_i);
    gpio_i <= 8'ha5;
    repeat (6) @(posedge clk_i);
    add_entry(1'b0, ao_addr(REG_GPIO_IN), '0, 32'h0000_00a5, 1'b0);
    add_entry(1'b1, ao_addr(REG_GPIO_INTR_EN), 32'h1 << IRQ_PIN, '0, 1'b0);
    apply_table();
    @(negedge clk_i);
    check_value("intr_o before edge", intr_o, 32'h0, err_cnt);
    @(posedge clk_i);
    gpio_i <= 8'ha5 | (8'h1 << IRQ_PIN);
    wait_irq(FAST_INTR_BASE + IRQ_PIN);
    check_value("intr_o after edge", intr_o, 32'h1 << (FAST_INTR_BASE + IRQ_PIN), err_cnt);
    add_entry(1'b1, ao_addr(REG_GPIO_INTR_STATUS), 32'h1 << IRQ_PIN, '0, 1'b0);
    apply_table();
    @(negedge clk_i);
    check_value("intr_o after clear", intr_o, 32'h0, err_cnt);

    assert_cnt = u_mini_mcu.u_mini_mcu_properties.violations;
    $display("errors: %0d checks, %0d responses, %0d assertions, %0d timeouts",
             err_cnt, rsp_err_cnt, assert_cnt, timeout_cnt);
    if (err_cnt + rsp_err_cnt + assert_cnt + timeout_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
